// File: axi_mem_tests.txt
# W id addr len burst, then data strb for each beat
# R id addr len burst, then the expected data for each beat
# INCR write and read back
W 1 0100 3 1 1111 3 2222 3 3333 3 4444 3
R 1 0100 3 1 1111 2222 3333 4444
# Partial strobes
W 2 0102 1 1 aa55 1 bbcc 2
R 2 0100 3 1 1111 2255 bb33 4444
# FIXED burst keeps the last beat
W 3 0202 0 1 5678 3
W 3 0200 3 0 0a0a 3 0b0b 3 0c0c 3 0d0d 3
R 4 0200 1 1 0d0d 5678
R 5 0200 2 0 0d0d 0d0d 0d0d
# INCR across the end of the RAM, then an alias of word 0
W 6 07fc 3 1 e001 3 e002 3 e003 3 e004 3
R 6 07fc 3 1 e001 e002 e003 e004
R 7 8800 1 1 e003 e004
# WRAP and reserved burst codes
W 8 0100 1 2 dead 3 beef 3
R 9 0100 1 2 0000 0000
R a 0100 1 1 1111 2255
W b 0104 0 3 ffff 3
R c 0104 0 3 0000
R c 0104 0 1 bb33
# Longer bursts under random back-pressure
W d 0400 7 1 1001 3 1002 3 1003 3 1004 3 1005 3 1006 3 1007 3 1008 3
R d 0400 7 1 1001 1002 1003 1004 1005 1006 1007 1008
R e 0400 7 1 1001 1002 1003 1004 1005 1006 1007 1008
R f 0406 4 0 1004 1004 1004 1004 1004

// File: sim.f
+incdir+.
axi_mem_pkg.sv
mem_port_if.sv
axi_mem_array.sv
axi_mem_wr.sv
axi_mem_rd.sv
axi_mem.sv
axi_mem_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the AXI memory testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --timescale 1ns/1ps -f sim.f --top-module axi_mem_tb \
  -o axi_mem_sim > build.log 2>&1 \
  && ./obj_dir/axi_mem_sim > sim.log 2>&1 \
  && grep -q "Simulation passed" sim.log \
  && echo "PASS" \
  || { echo "FAIL, see build.log and sim.log"; exit 1; }

// File: axi_mem_tb.sv
`timescale 1ns/1ps
`include "axi_mem_defs.svh"

module axi_mem_tb
  import axi_mem_pkg::*;
();

  localparam int depth = 2 ** `AXI_MEM_DEPTH_LOG2;
  localparam int byte_shift = $clog2(`AXI_MEM_DATA_W / 8);
  localparam int num_bytes = `AXI_MEM_DATA_W / 8;

  logic       clk;
  logic       rst_n;
  logic       awvalid;
  id_t        awid;
  addr_t      awaddr;
  len_t       awlen;
  logic [2:0] awsize;
  burst_t     awburst;
  logic       awready;
  logic       wvalid;
  data_t      wdata;
  strb_t      wstrb;
  logic       wlast;
  logic       wready;
  logic       bvalid;
  id_t        bid;
  resp_t      bresp;
  logic       bready;
  logic       arvalid;
  id_t        arid;
  addr_t      araddr;
  len_t       arlen;
  logic [2:0] arsize;
  burst_t     arburst;
  logic       arready;
  logic       rvalid;
  id_t        rid;
  data_t      rdata;
  resp_t      rresp;
  logic       rlast;
  logic       rready;

  logic        tests_loaded;
  int          num_tests;
  int          mismatches;
  int          failures;
  logic [31:0] lcg_state;

  // One entry per test line, beats kept in flat queues
  logic   test_is_write [$];
  id_t    test_id [$];
  addr_t  test_addr [$];
  len_t   test_len [$];
  burst_t test_burst [$];
  int     test_first [$];
  data_t  beat_data [$];
  strb_t  beat_strb [$];

  // Byte model used to cross-check the tests file
  data_t model [depth];

  axi_mem dut0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .s_axi_awvalid (awvalid),
    .s_axi_awid    (awid),
    .s_axi_awaddr  (awaddr),
    .s_axi_awlen   (awlen),
    .s_axi_awsize  (awsize),
    .s_axi_awburst (awburst),
    .s_axi_awready (awready),
    .s_axi_wvalid  (wvalid),
    .s_axi_wdata   (wdata),
    .s_axi_wstrb   (wstrb),
    .s_axi_wlast   (wlast),
    .s_axi_wready  (wready),
    .s_axi_bvalid  (bvalid),
    .s_axi_bid     (bid),
    .s_axi_bresp   (bresp),
    .s_axi_bready  (bready),
    .s_axi_arvalid (arvalid),
    .s_axi_arid    (arid),
    .s_axi_araddr  (araddr),
    .s_axi_arlen   (arlen),
    .s_axi_arsize  (arsize),
    .s_axi_arburst (arburst),
    .s_axi_arready (arready),
    .s_axi_rvalid  (rvalid),
    .s_axi_rid     (rid),
    .s_axi_rdata   (rdata),
    .s_axi_rresp   (rresp),
    .s_axi_rlast   (rlast),
    .s_axi_rready  (rready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // LCG step, high about 70% of the time
  function automatic logic random_ready();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:24] < 8'd179;
  endfunction

  function automatic word_addr_t word_of(input addr_t a);
    return word_addr_t'(a >> byte_shift);
  endfunction

  function automatic resp_t resp_for(input burst_t b);
    if (b == `AXI_MEM_BURST_FIXED || b == `AXI_MEM_BURST_INCR) begin
      return `AXI_MEM_RESP_OKAY;
    end else begin
      return `AXI_MEM_RESP_SLVERR;
    end
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("MISMATCH %s: expected %0h, got %0h at %0t", name, exp, got, $time);
    mismatches++;
  endtask

  task automatic report_failure(input string what);
    $display("ERROR: %s at %0t", what, $time);
    failures++;
  endtask

  task automatic load_tests();
    int          fd;
    int          rc;
    int          c;
    string       kind;
    logic [31:0] id;
    logic [31:0] addr;
    logic [31:0] len;
    logic [31:0] burst;
    logic [31:0] d;
    logic [31:0] s;
    word_addr_t  w;
    data_t       expect_d;
    for (int i = 0; i < depth; i++) begin
      model[i] = '0;
    end
    fd = $fopen("axi_mem_tests.txt", "r");
    if (fd == 0) begin
      report_failure("cannot open axi_mem_tests.txt");
      return;
    end
    while (1) begin
      rc = $fscanf(fd, "%s", kind);
      if (rc != 1) begin
        break;
      end
      if (kind.substr(0, 0) == "#") begin
        c = 0;
        while (c != 10 && c != -1) begin
          c = $fgetc(fd);
        end
        continue;
      end
      rc = $fscanf(fd, "%h %h %h %h", id, addr, len, burst);
      if (rc != 4 || (kind != "W" && kind != "R")) begin
        report_failure($sformatf("malformed line in tests file after test %0d", test_id.size()));
        break;
      end
      test_is_write.push_back(kind == "W");
      test_id.push_back(id_t'(id));
      test_addr.push_back(addr_t'(addr));
      test_len.push_back(len_t'(len));
      test_burst.push_back(burst_t'(burst));
      test_first.push_back(beat_data.size());
      w = word_of(addr_t'(addr));
      for (int b = 0; b <= int'(len[7:0]); b++) begin
        if (kind == "W") begin
          rc = $fscanf(fd, "%h %h", d, s);
          beat_data.push_back(data_t'(d));
          beat_strb.push_back(strb_t'(s));
          if (resp_for(burst_t'(burst)) == `AXI_MEM_RESP_OKAY) begin
            for (int i = 0; i < num_bytes; i++) begin
              if (s[i]) begin
                model[w][i*8 +: 8] = d[i*8 +: 8];
              end
            end
          end
        end else begin
          rc = $fscanf(fd, "%h", d);
          beat_data.push_back(data_t'(d));
          beat_strb.push_back('0);
          expect_d = (resp_for(burst_t'(burst)) == `AXI_MEM_RESP_OKAY) ? model[w] : '0;
          if (expect_d != data_t'(d)) begin
            report_failure($sformatf("tests file, test %0d beat %0d disagrees with the model",
                                     test_id.size(), b));
          end
        end
        if (burst_t'(burst) == `AXI_MEM_BURST_INCR) begin
          w = w + 1'b1;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic do_write(input int t);
    int   base;
    int   n;
    logic take;
    base = test_first[t];
    n = int'(test_len[t]) + 1;
    @(negedge clk);
    awvalid = 1'b1;
    awid = test_id[t];
    awaddr = test_addr[t];
    awlen = test_len[t];
    awburst = test_burst[t];
    take = awready;
    while (!take) begin
      @(negedge clk);
      take = awready;
    end
    @(negedge clk);
    awvalid = 1'b0;
    for (int beat = 0; beat < n; beat++) begin
      wvalid = 1'b1;
      wdata = beat_data[base + beat];
      wstrb = beat_strb[base + beat];
      wlast = (beat == n - 1);
      take = wready;
      while (!take) begin
        @(negedge clk);
        take = wready;
      end
      @(negedge clk);
    end
    wvalid = 1'b0;
    wlast = 1'b0;
    bready = random_ready();
    while (!(bvalid && bready)) begin
      @(negedge clk);
      bready = random_ready();
    end
    if (bid != test_id[t]) begin
      report_mismatch("bid", 32'(test_id[t]), 32'(bid));
    end
    if (bresp != resp_for(test_burst[t])) begin
      report_mismatch("bresp", 32'(resp_for(test_burst[t])), 32'(bresp));
    end
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic do_read(input int t);
    int    base;
    int    n;
    int    beat;
    int    cyc;
    logic  take;
    logic  seen;
    logic  stalled;
    data_t held;
    base = test_first[t];
    n = int'(test_len[t]) + 1;
    @(negedge clk);
    rready = 1'b0;
    arvalid = 1'b1;
    arid = test_id[t];
    araddr = test_addr[t];
    arlen = test_len[t];
    arburst = test_burst[t];
    take = arready;
    while (!take) begin
      @(negedge clk);
      take = arready;
    end
    beat = 0;
    cyc = 0;
    seen = 1'b0;
    stalled = 1'b0;
    held = '0;
    while (beat < n) begin
      @(negedge clk);
      arvalid = 1'b0;
      cyc++;
      rready = random_ready();
      if (stalled) begin
        if (!rvalid) begin
          report_failure("rvalid dropped while a beat was stalled");
        end else if (rdata != held) begin
          report_mismatch("rdata (stalled)", 32'(held), 32'(rdata));
        end
      end
      // AR edge plus two rising edges
      if (rvalid && !seen) begin
        seen = 1'b1;
        if (cyc - 1 != 2) begin
          report_failure($sformatf("first rvalid came %0d cycles after AR", cyc - 1));
        end
      end
      if (rvalid && rready) begin
        if (rid != test_id[t]) begin
          report_mismatch("rid", 32'(test_id[t]), 32'(rid));
        end
        if (rresp != resp_for(test_burst[t])) begin
          report_mismatch("rresp", 32'(resp_for(test_burst[t])), 32'(rresp));
        end
        if (rdata != beat_data[base + beat]) begin
          report_mismatch("rdata", 32'(beat_data[base + beat]), 32'(rdata));
        end
        if (rlast != (beat == n - 1)) begin
          report_mismatch("rlast", 32'(beat == n - 1), 32'(rlast));
        end
        beat++;
        stalled = 1'b0;
      end else begin
        stalled = rvalid;
        held = rdata;
      end
    end
    @(negedge clk);
    rready = 1'b0;
    if (rvalid) begin
      report_failure("rvalid still high after the last beat of the burst");
    end
  endtask

  initial begin
    wait (tests_loaded);
    repeat (200 * num_tests + 100) @(posedge clk);
    report_failure("timeout, the tests did not finish in time");
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    rst_n = 1'b0;
    awvalid = 1'b0;
    awid = '0;
    awaddr = '0;
    awlen = '0;
    awsize = 3'd1;
    awburst = '0;
    wvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wlast = 1'b0;
    bready = 1'b0;
    arvalid = 1'b0;
    arid = '0;
    araddr = '0;
    arlen = '0;
    arsize = 3'd1;
    arburst = '0;
    rready = 1'b0;
    mismatches = 0;
    failures = 0;
    tests_loaded = 1'b0;
    lcg_state = 32'h5bbf2990;
    load_tests();
    num_tests = test_id.size();
    tests_loaded = 1'b1;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    if (awready != 1'b1) begin
      report_mismatch("awready", 32'h1, 32'(awready));
    end
    if (arready != 1'b1) begin
      report_mismatch("arready", 32'h1, 32'(arready));
    end
    if (wready != 1'b0) begin
      report_mismatch("wready", 32'h0, 32'(wready));
    end
    if (bvalid != 1'b0) begin
      report_mismatch("bvalid", 32'h0, 32'(bvalid));
    end
    if (rvalid != 1'b0) begin
      report_mismatch("rvalid", 32'h0, 32'(rvalid));
    end
    for (int t = 0; t < num_tests; t++) begin
      if (test_is_write[t]) begin
        do_write(t);
      end else begin
        do_read(t);
      end
    end
    @(negedge clk);
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0 && num_tests > 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: axi_mem.sv
`timescale 1ns/1ps

module axi_mem
  import axi_mem_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  input  logic       s_axi_awvalid,
  input  id_t        s_axi_awid,
  input  addr_t      s_axi_awaddr,
  input  len_t       s_axi_awlen,
  input  logic [2:0] s_axi_awsize,
  input  burst_t     s_axi_awburst,
  output logic       s_axi_awready,

  input  logic       s_axi_wvalid,
  input  data_t      s_axi_wdata,
  input  strb_t      s_axi_wstrb,
  input  logic       s_axi_wlast,
  output logic       s_axi_wready,

  output logic       s_axi_bvalid,
  output id_t        s_axi_bid,
  output resp_t      s_axi_bresp,
  input  logic       s_axi_bready,

  input  logic       s_axi_arvalid,
  input  id_t        s_axi_arid,
  input  addr_t      s_axi_araddr,
  input  len_t       s_axi_arlen,
  input  logic [2:0] s_axi_arsize,
  input  burst_t     s_axi_arburst,
  output logic       s_axi_arready,

  output logic       s_axi_rvalid,
  output id_t        s_axi_rid,
  output data_t      s_axi_rdata,
  output resp_t      s_axi_rresp,
  output logic       s_axi_rlast,
  input  logic       s_axi_rready
);

  // Every beat is a full word, so awsize and arsize carry no information here

  mem_port_if wr_port ();
  mem_port_if rd_port ();

  axi_mem_wr wr0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .awvalid (s_axi_awvalid),
    .awid    (s_axi_awid),
    .awaddr  (s_axi_awaddr),
    .awlen   (s_axi_awlen),
    .awburst (s_axi_awburst),
    .awready (s_axi_awready),
    .wvalid  (s_axi_wvalid),
    .wdata   (s_axi_wdata),
    .wstrb   (s_axi_wstrb),
    .wlast   (s_axi_wlast),
    .wready  (s_axi_wready),
    .bvalid  (s_axi_bvalid),
    .bid     (s_axi_bid),
    .bresp   (s_axi_bresp),
    .bready  (s_axi_bready),
    .mem     (wr_port.wr)
  );

  axi_mem_rd rd0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .arvalid (s_axi_arvalid),
    .arid    (s_axi_arid),
    .araddr  (s_axi_araddr),
    .arlen   (s_axi_arlen),
    .arburst (s_axi_arburst),
    .arready (s_axi_arready),
    .rvalid  (s_axi_rvalid),
    .rid     (s_axi_rid),
    .rdata   (s_axi_rdata),
    .rresp   (s_axi_rresp),
    .rlast   (s_axi_rlast),
    .rready  (s_axi_rready),
    .mem     (rd_port.rd)
  );

  axi_mem_array array0 (
    .clk (clk),
    .wr  (wr_port.ram),
    .rd  (rd_port.ram)
  );

endmodule

// File: axi_mem_rd.sv
`timescale 1ns/1ps
`include "axi_mem_defs.svh"

module axi_mem_rd
  import axi_mem_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,

  input  logic   arvalid,
  input  id_t    arid,
  input  addr_t  araddr,
  input  len_t   arlen,
  input  burst_t arburst,
  output logic   arready,

  output logic   rvalid,
  output id_t    rid,
  output data_t  rdata,
  output resp_t  rresp,
  output logic   rlast,
  input  logic   rready,

  mem_port_if.rd mem
);

  localparam int byte_shift = $clog2(`AXI_MEM_DATA_W / 8);

  rd_state_t  state;
  id_t        id_q;
  word_addr_t addr_q;
  burst_t     burst_q;
  len_t       len_q;
  resp_t      resp_q;
  logic [8:0] issue_cnt;
  len_t       dlv_cnt;
  logic       ram_vld;
  logic       skid_vld;
  data_t      skid_data;
  data_t      out_data;
  data_t      ram_data;
  logic       ar_fire;
  logic       issue;
  logic       pop;
  logic       out_free;

  assign arready  = (state == rd_idle);
  assign ar_fire  = arvalid && arready;
  assign pop      = rvalid && rready;
  assign out_free = !rvalid || rready;

  // Reads stop while the output beat is stalled
  assign issue = (state == rd_burst) && (issue_cnt <= {1'b0, len_q}) && out_free;

  assign mem.en   = issue && (resp_q == `AXI_MEM_RESP_OKAY);
  assign mem.addr = addr_q;

  // Error bursts return zero
  assign ram_data = (resp_q == `AXI_MEM_RESP_OKAY) ? mem.rdata : '0;

  assign rid   = id_q;
  assign rresp = resp_q;
  assign rdata = out_data;
  assign rlast = rvalid && (dlv_cnt == len_q);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= rd_idle;
      rvalid   <= 1'b0;
      ram_vld  <= 1'b0;
      skid_vld <= 1'b0;
    end else begin
      ram_vld <= issue;
      if (out_free) begin
        rvalid   <= skid_vld || ram_vld;
        skid_vld <= skid_vld && ram_vld;
      end else if (ram_vld) begin
        skid_vld <= 1'b1;
      end
      case (state)
        rd_idle: begin
          if (ar_fire) begin
            state <= rd_burst;
          end
        end
        rd_burst: begin
          if (pop && rlast) begin
            state <= rd_idle;
          end
        end
        default: state <= rd_idle;
      endcase
    end
  end

  // Burst context, counters and the data path
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      id_q      <= arid;
      addr_q    <= word_addr_t'(araddr >> byte_shift);
      burst_q   <= arburst;
      len_q     <= arlen;
      issue_cnt <= '0;
      dlv_cnt   <= '0;
      if (arburst == `AXI_MEM_BURST_FIXED || arburst == `AXI_MEM_BURST_INCR) begin
        resp_q <= `AXI_MEM_RESP_OKAY;
      end else begin
        resp_q <= `AXI_MEM_RESP_SLVERR;
      end
    end
    if (issue) begin
      issue_cnt <= issue_cnt + 9'd1;
      if (burst_q == `AXI_MEM_BURST_INCR) begin
        addr_q <= addr_q + 1'b1;
      end
    end
    if (pop) begin
      dlv_cnt <= dlv_cnt + 8'd1;
    end
    // Skid beat goes first, it is older than the RAM beat
    if (out_free) begin
      if (skid_vld) begin
        out_data <= skid_data;
      end else if (ram_vld) begin
        out_data <= ram_data;
      end
    end
    if (ram_vld && (!out_free || skid_vld)) begin
      skid_data <= ram_data;
    end
  end

endmodule

// File: axi_mem_wr.sv
`timescale 1ns/1ps
`include "axi_mem_defs.svh"

module axi_mem_wr
  import axi_mem_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,

  input  logic   awvalid,
  input  id_t    awid,
  input  addr_t  awaddr,
  input  len_t   awlen,
  input  burst_t awburst,
  output logic   awready,

  input  logic   wvalid,
  input  data_t  wdata,
  input  strb_t  wstrb,
  input  logic   wlast,
  output logic   wready,

  output logic   bvalid,
  output id_t    bid,
  output resp_t  bresp,
  input  logic   bready,

  mem_port_if.wr mem
);

  localparam int byte_shift = $clog2(`AXI_MEM_DATA_W / 8);

  wr_state_t  state;
  id_t        id_q;
  word_addr_t addr_q;
  burst_t     burst_q;
  resp_t      resp_q;
  logic       aw_fire;
  logic       w_fire;

  assign awready = (state == wr_idle);
  assign wready  = (state == wr_data);
  assign bvalid  = (state == wr_resp);
  assign bid     = id_q;
  assign bresp   = resp_q;

  assign aw_fire  = awvalid && awready;
  assign w_fire   = wvalid && wready;

  // RAM write lands on the same edge as the W transfer
  assign mem.en    = w_fire && (resp_q == `AXI_MEM_RESP_OKAY);
  assign mem.we    = mem.en;
  assign mem.addr  = addr_q;
  assign mem.wdata = wdata;
  assign mem.wstrb = wstrb;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= wr_idle;
    end else begin
      case (state)
        wr_idle: begin
          if (aw_fire) begin
            state <= wr_data;
          end
        end
        wr_data: begin
          if (w_fire && wlast) begin
            state <= wr_resp;
          end
        end
        wr_resp: begin
          if (bready) begin
            state <= wr_idle;
          end
        end
        default: state <= wr_idle;
      endcase
    end
  end

  // Burst context and address stepping
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      id_q     <= awid;
      addr_q   <= word_addr_t'(awaddr >> byte_shift);
      burst_q  <= awburst;
      if (awburst == `AXI_MEM_BURST_FIXED || awburst == `AXI_MEM_BURST_INCR) begin
        resp_q <= `AXI_MEM_RESP_OKAY;
      end else begin
        resp_q <= `AXI_MEM_RESP_SLVERR;
      end
    end else if (w_fire) begin
      if (burst_q == `AXI_MEM_BURST_INCR) begin
        addr_q <= addr_q + 1'b1;
      end
    end
  end

endmodule

// File: axi_mem_array.sv
`timescale 1ns/1ps
`include "axi_mem_defs.svh"

module axi_mem_array
  import axi_mem_pkg::*;
(
  input logic     clk,
  mem_port_if.ram wr,
  mem_port_if.ram rd
);

  localparam int depth = 2 ** `AXI_MEM_DEPTH_LOG2;
  localparam int num_bytes = `AXI_MEM_DATA_W / 8;

  data_t mem [depth];

  // Byte-masked write
  always_ff @(posedge clk) begin
    if (wr.en && wr.we) begin
      for (int i = 0; i < num_bytes; i++) begin
        if (wr.wstrb[i]) begin
          mem[wr.addr][i*8 +: 8] <= wr.wdata[i*8 +: 8];
        end
      end
    end
  end

  // Registered read returns old data on a same-word collision
  always_ff @(posedge clk) begin
    if (rd.en) begin
      rd.rdata <= mem[rd.addr];
    end
  end

endmodule

// File: mem_port_if.sv
`timescale 1ns/1ps

interface mem_port_if
  import axi_mem_pkg::*;
();

  logic       en;
  logic       we;
  word_addr_t addr;
  data_t      wdata;
  strb_t      wstrb;
  data_t      rdata;

  // Write engine side
  modport wr (output en, output we, output addr, output wdata, output wstrb);

  // Read engine side, rdata arrives one cycle after en
  modport rd (output en, output addr, input rdata);

  modport ram (input en, input we, input addr, input wdata, input wstrb, output rdata);

endinterface

// File: axi_mem_pkg.sv
`include "axi_mem_defs.svh"

package axi_mem_pkg;

  // AXI payload fields
  typedef logic [`AXI_MEM_ADDR_W-1:0] addr_t;
  typedef logic [`AXI_MEM_DATA_W-1:0] data_t;
  typedef logic [`AXI_MEM_DATA_W/8-1:0] strb_t;
  typedef logic [`AXI_MEM_ID_W-1:0] id_t;
  typedef logic [7:0] len_t;
  typedef logic [1:0] burst_t;
  typedef logic [1:0] resp_t;

  // RAM word index
  typedef logic [`AXI_MEM_DEPTH_LOG2-1:0] word_addr_t;

  typedef enum logic [1:0] {
    wr_idle,
    wr_data,
    wr_resp
  } wr_state_t;

  typedef enum logic {
    rd_idle,
    rd_burst
  } rd_state_t;

endpackage

// File: axi_mem_defs.svh
`ifndef AXI_MEM_DEFS_SVH
`define AXI_MEM_DEFS_SVH

// Bus widths
`define AXI_MEM_ADDR_W 16
`define AXI_MEM_DATA_W 16
`define AXI_MEM_ID_W 4

// RAM word address bits, the depth is a power of two
`define AXI_MEM_DEPTH_LOG2 10

// Response codes
`define AXI_MEM_RESP_OKAY 2'd0
`define AXI_MEM_RESP_SLVERR 2'd2

// Burst codes that are carried out
`define AXI_MEM_BURST_FIXED 2'd0
`define AXI_MEM_BURST_INCR 2'd1

`endif
